/* verilog/mmu_settings.svh */
// sv39 data-side translation settings
// address widths, dtlb size, asid width and page fault cause codes
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// ------------------------------
// address widths
// ------------------------------
// sv39 virtual address
`define MMU_VLEN 39
`define MMU_PLEN 56
// ppn width, plen minus the 12-bit page offset
`define MMU_PPNW 44
// three 9-bit vpn fields
`define MMU_VPNW 27

// ------------------------------
// dtlb and asid
// ------------------------------
`define MMU_TLB_ENTRIES 4
`define MMU_ASIDW 8

// ------------------------------
// exception cause codes (mcause encoding)
// ------------------------------
`define MMU_CAUSE_LD_PF 13
`define MMU_CAUSE_ST_PF 15

`endif

/* verilog/mmu_pkg.sv */
// types shared by the sv39 data-side translation path
`include "mmu_settings.svh"

package mmu_pkg;

    // privilege levels, hypervisor encoding unused
    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'd0,
        PRIV_LVL_S = 2'd1,
        PRIV_LVL_M = 2'd3
    } priv_lvl_t;

    // sv39 leaf pte, rsw and reserved bits dropped
    typedef struct packed {
        logic [`MMU_PPNW-1:0] ppn;
        logic                 d;
        logic                 a;
        logic                 g;
        logic                 u;
        logic                 x;
        logic                 w;
        logic                 r;
        logic                 v;
    } pte_t;

    // refill from the load/store side, sampled while valid is high
    typedef struct packed {
        logic                  valid;
        logic [`MMU_VPNW-1:0]  vpn;
        logic [`MMU_ASIDW-1:0] asid;
        pte_t                  pte;
        logic                  is_2m;
        logic                  is_1g;
    } tlb_update_t;

    // lookup result from the dtlb
    typedef struct packed {
        logic hit;
        pte_t pte;
        logic is_2m;
        logic is_1g;
    } tlb_hit_t;

    typedef struct packed {
        logic [`MMU_VLEN-1:0] vaddr;
        logic                 is_store;
    } xlate_req_t;

    // response, valid one cycle after the request
    typedef struct packed {
        logic [`MMU_PLEN-1:0] paddr;
        logic                 miss;
        logic                 ex_valid;
        logic [3:0]           ex_cause;
        logic [`MMU_VLEN-1:0] ex_tval;
    } xlate_rsp_t;

endpackage

/* verilog/dtlb.sv */
// fully associative data tlb with asid tags and global pages
// combinational lookup, round-robin refill and full flush
`include "mmu_settings.svh"

module dtlb (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  mmu_pkg::tlb_update_t       update_i,
    input  logic [`MMU_VLEN-1:0]       lu_vaddr_i,
    input  logic [`MMU_ASIDW-1:0]      lu_asid_i,
    output mmu_pkg::tlb_hit_t          lu_o
);

    localparam int unsigned N     = `MMU_TLB_ENTRIES;
    localparam int unsigned PTR_W = (N > 1) ? $clog2(N) : 1;

    // per-entry tag, vpn split into the three sv39 levels
    typedef struct packed {
        logic [8:0]            vpn2;
        logic [8:0]            vpn1;
        logic [8:0]            vpn0;
        logic [`MMU_ASIDW-1:0] asid;
        logic                  is_2m;
        logic                  is_1g;
    } tag_t;

    tag_t              tag_q [N];
    mmu_pkg::pte_t     pte_q [N];
    logic [N-1:0]      valid_q;
    logic [PTR_W-1:0]  ptr_q;
    logic [N-1:0]      match;
    logic [8:0]        lu_vpn2;
    logic [8:0]        lu_vpn1;
    logic [8:0]        lu_vpn0;

    assign lu_vpn2 = lu_vaddr_i[`MMU_VLEN-1:30];
    assign lu_vpn1 = lu_vaddr_i[29:21];
    assign lu_vpn0 = lu_vaddr_i[20:12];

    // ------------------------------
    // lookup
    // ------------------------------
    always_comb begin : match_logic
        for (int i = 0; i < N; i++) begin
            // asid only matters for non-global pages
            // superpages ignore the lower vpn fields
            match[i] = valid_q[i]
                && (tag_q[i].asid == lu_asid_i || pte_q[i].g)
                && (tag_q[i].vpn2 == lu_vpn2)
                && (tag_q[i].is_1g || tag_q[i].vpn1 == lu_vpn1)
                && (tag_q[i].is_1g || tag_q[i].is_2m || tag_q[i].vpn0 == lu_vpn0);
        end
    end

    // walk downwards so the lowest matching index wins
    always_comb begin : select_logic
        lu_o = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (match[i]) begin
                lu_o.hit   = 1'b1;
                lu_o.pte   = pte_q[i];
                lu_o.is_2m = tag_q[i].is_2m;
                lu_o.is_1g = tag_q[i].is_1g;
            end
        end
    end

    // ------------------------------
    // valid bits and refill pointer
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            ptr_q   <= '0;
        end else if (flush_i) begin
            // flush wins over a refill in the same cycle
            valid_q <= '0;
            ptr_q   <= '0;
        end else if (update_i.valid) begin
            valid_q[ptr_q] <= 1'b1;
            ptr_q          <= (ptr_q == PTR_W'(N - 1)) ? '0 : ptr_q + 1'b1;
        end
    end

    // entry contents, written at the pointer
    always_ff @(posedge clk_i) begin
        if (update_i.valid && !flush_i) begin
            tag_q[ptr_q].vpn2  <= update_i.vpn[26:18];
            tag_q[ptr_q].vpn1  <= update_i.vpn[17:9];
            tag_q[ptr_q].vpn0  <= update_i.vpn[8:0];
            tag_q[ptr_q].asid  <= update_i.asid;
            tag_q[ptr_q].is_2m <= update_i.is_2m;
            tag_q[ptr_q].is_1g <= update_i.is_1g;
            pte_q[ptr_q]       <= update_i.pte;
        end
    end

endmodule

/* verilog/page_resolve.sv */
// forms the physical address for 4K, 2M and 1G pages
// and checks the pte permission bits for load/store page faults
`include "mmu_settings.svh"

module page_resolve (
    input  logic [`MMU_VLEN-1:0]  vaddr_i,
    input  mmu_pkg::tlb_hit_t     hit_i,
    input  logic                  is_store_i,
    input  mmu_pkg::priv_lvl_t    priv_lvl_i,
    input  logic                  sum_i,
    output logic [`MMU_PLEN-1:0]  paddr_o,
    output logic                  fault_o
);

    logic priv_err;
    logic store_err;

    // ------------------------------
    // physical address
    // ------------------------------
    always_comb begin : paddr_logic
        // 4K page, ppn plus offset
        paddr_o = {hit_i.pte.ppn, vaddr_i[11:0]};
        // megapage keeps vpn0 from the virtual address
        if (hit_i.is_2m) begin
            paddr_o[20:12] = vaddr_i[20:12];
        end
        // gigapage keeps vpn1 and vpn0
        if (hit_i.is_1g) begin
            paddr_o[29:12] = vaddr_i[29:12];
        end
    end

    // ------------------------------
    // permission checks
    // ------------------------------
    // supervisor may touch user pages only with sum set
    assign priv_err = ((priv_lvl_i == mmu_pkg::PRIV_LVL_S) && !sum_i && hit_i.pte.u)
                   || ((priv_lvl_i == mmu_pkg::PRIV_LVL_U) && !hit_i.pte.u);

    // stores also need write permission and the dirty bit
    assign store_err = is_store_i && (!hit_i.pte.w || !hit_i.pte.d);

    // only meaningful for an entry that actually hit
    assign fault_o = hit_i.hit && (priv_err || store_err);

endmodule

/* verilog/xlate_ctrl.sv */
// request stage of the data translation path
// registers request and lookup, then builds the response one cycle later
`include "mmu_settings.svh"

module xlate_ctrl (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   req_i,
    input  mmu_pkg::xlate_req_t    xlate_req_i,
    input  logic                   en_trans_i,
    input  mmu_pkg::tlb_hit_t      lu_i,
    input  logic [`MMU_PLEN-1:0]   paddr_i,
    input  logic                   fault_i,
    output mmu_pkg::tlb_hit_t      hit_q_o,
    output mmu_pkg::xlate_req_t    req_q_o,
    output logic                   lsu_hit_o,
    output logic                   lsu_valid_o,
    output mmu_pkg::xlate_rsp_t    xlate_rsp_o
);

    logic req_q;
    logic en_trans_q;

    // same-cycle hit, bypass always hits
    assign lsu_hit_o = en_trans_i ? lu_i.hit : 1'b1;

    // ------------------------------
    // request stage
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q      <= 1'b0;
            en_trans_q <= 1'b0;
        end else begin
            req_q <= req_i;
            // translation mode travels with its request
            if (req_i) begin
                en_trans_q <= en_trans_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            req_q_o <= xlate_req_i;
            hit_q_o <= lu_i;
        end
    end

    assign lsu_valid_o = req_q;

    // ------------------------------
    // response
    // ------------------------------
    always_comb begin : rsp_logic
        xlate_rsp_o       = '0;
        // bypass, zero-extended vaddr
        xlate_rsp_o.paddr = {{(`MMU_PLEN - `MMU_VLEN){1'b0}}, req_q_o.vaddr};
        if (en_trans_q) begin
            xlate_rsp_o.paddr = paddr_i;
            if (!hit_q_o.hit) begin
                // no walker here, the lsu refills and retries
                xlate_rsp_o.miss = 1'b1;
            end else if (fault_i) begin
                xlate_rsp_o.ex_valid = 1'b1;
                xlate_rsp_o.ex_cause = req_q_o.is_store ? 4'(`MMU_CAUSE_ST_PF)
                                                        : 4'(`MMU_CAUSE_LD_PF);
                xlate_rsp_o.ex_tval  = req_q_o.vaddr;
            end
        end
    end

endmodule

/* verilog/mmu_top.sv */
// sv39 data-side mmu, dtlb lookup plus one-cycle translation stage
`include "mmu_settings.svh"

module mmu_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  mmu_pkg::tlb_update_t    tlb_update_i,
    input  logic                    lsu_req_i,
    input  mmu_pkg::xlate_req_t     xlate_req_i,
    input  logic                    en_trans_i,
    input  mmu_pkg::priv_lvl_t      priv_lvl_i,
    input  logic                    sum_i,
    input  logic [`MMU_ASIDW-1:0]   asid_i,
    output logic                    lsu_hit_o,
    output logic                    lsu_valid_o,
    output mmu_pkg::xlate_rsp_t     xlate_rsp_o
);

    mmu_pkg::tlb_hit_t     lu;
    mmu_pkg::tlb_hit_t     hit_q;
    mmu_pkg::xlate_req_t   req_q;
    logic [`MMU_PLEN-1:0]  paddr;
    logic                  fault;

    dtlb i_dtlb (
        .clk_i      ( clk_i             ),
        .rst_ni     ( rst_ni            ),
        .flush_i    ( flush_i           ),
        .update_i   ( tlb_update_i      ),
        .lu_vaddr_i ( xlate_req_i.vaddr ),
        .lu_asid_i  ( asid_i            ),
        .lu_o       ( lu                )
    );

    // resolver works on the registered request
    page_resolve i_page_resolve (
        .vaddr_i    ( req_q.vaddr       ),
        .hit_i      ( hit_q             ),
        .is_store_i ( req_q.is_store    ),
        .priv_lvl_i ( priv_lvl_i        ),
        .sum_i      ( sum_i             ),
        .paddr_o    ( paddr             ),
        .fault_o    ( fault             )
    );

    xlate_ctrl i_xlate_ctrl (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .req_i       ( lsu_req_i   ),
        .xlate_req_i ( xlate_req_i ),
        .en_trans_i  ( en_trans_i  ),
        .lu_i        ( lu          ),
        .paddr_i     ( paddr       ),
        .fault_i     ( fault       ),
        .hit_q_o     ( hit_q       ),
        .req_q_o     ( req_q       ),
        .lsu_hit_o   ( lsu_hit_o   ),
        .lsu_valid_o ( lsu_valid_o ),
        .xlate_rsp_o ( xlate_rsp_o )
    );

endmodule

/* tb/mmu_sva.sv */
// protocol assertions on the mmu top level
// bound into every mmu_top instance
module mmu_sva (
    input logic                clk_i,
    input logic                rst_ni,
    input logic                lsu_req_i,
    input logic                lsu_valid_i,
    input mmu_pkg::xlate_rsp_t rsp_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // one response per request, exactly one cycle later
    valid_follows_req: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_i == $past(lsu_req_i)
    ) else $error("lsu_valid_o does not follow lsu_req_i by one cycle");

    // a miss never carries an exception
    exception_not_miss: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (lsu_valid_i && rsp_i.ex_valid) |-> !rsp_i.miss
    ) else $error("exception raised on a tlb miss");

    valid_low_in_reset: assert property (
        @(posedge clk_i) !rst_ni |-> !lsu_valid_i
    ) else $error("lsu_valid_o high during reset");

endmodule

bind mmu_top mmu_sva i_mmu_sva (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .lsu_req_i   ( lsu_req_i   ),
    .lsu_valid_i ( lsu_valid_o ),
    .rsp_i       ( xlate_rsp_o )
);

/* tb/mmu_tb.sv */
// testbench for the sv39 data-side mmu
// replays tb/mmu_stimulus.txt and checks hit, response and exception fields
`include "mmu_settings.svh"

module mmu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 16;

    // expected response of one outstanding lookup
    typedef struct packed {
        logic [`MMU_VLEN-1:0] vaddr;
        logic [`MMU_PLEN-1:0] paddr;
        logic                 miss;
        logic                 ex_valid;
        logic [3:0]           cause;
    } lookup_exp_t;

    logic                  clk_i;
    logic                  rst_ni;
    logic                  flush_i;
    mmu_pkg::tlb_update_t  tlb_update_i;
    logic                  lsu_req_i;
    mmu_pkg::xlate_req_t   xlate_req_i;
    logic                  en_trans_i;
    mmu_pkg::priv_lvl_t    priv_lvl_i;
    logic                  sum_i;
    logic [`MMU_ASIDW-1:0] asid_i;
    logic                  lsu_hit_o;
    logic                  lsu_valid_o;
    mmu_pkg::xlate_rsp_t   xlate_rsp_o;

    // lookups still waiting for lsu_valid_o in request order
    lookup_exp_t exp_q [$];
    int          n_rsp;

    mmu_top dut0 (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .flush_i      ( flush_i      ),
        .tlb_update_i ( tlb_update_i ),
        .lsu_req_i    ( lsu_req_i    ),
        .xlate_req_i  ( xlate_req_i  ),
        .en_trans_i   ( en_trans_i   ),
        .priv_lvl_i   ( priv_lvl_i   ),
        .sum_i        ( sum_i        ),
        .asid_i       ( asid_i       ),
        .lsu_hit_o    ( lsu_hit_o    ),
        .lsu_valid_o  ( lsu_valid_o  ),
        .xlate_rsp_o  ( xlate_rsp_o  )
    );

    // 8 ns clock
    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // strobes last a single cycle
    task automatic clear_strobes();
        lsu_req_i          <= 1'b0;
        flush_i            <= 1'b0;
        tlb_update_i.valid <= 1'b0;
    endtask

    // compare a response with the oldest outstanding lookup
    task automatic collect_response();
        lookup_exp_t e;
        if (lsu_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("lsu_valid_o was raised without an outstanding request");
                abort_run();
            end else begin
                e = exp_q.pop_front();
                check_value("xlate_rsp_o.miss", xlate_rsp_o.miss, e.miss);
                check_value("xlate_rsp_o.ex_valid", xlate_rsp_o.ex_valid, e.ex_valid);
                check_value("xlate_rsp_o.ex_cause", xlate_rsp_o.ex_cause, e.cause);
                // tval carries the faulting vaddr or zero
                check_value("xlate_rsp_o.ex_tval", xlate_rsp_o.ex_tval,
                            e.ex_valid ? e.vaddr : '0);
                // paddr has no meaning on a miss
                if (!e.miss) begin
                    check_value("xlate_rsp_o.paddr", xlate_rsp_o.paddr, e.paddr);
                end
                n_rsp++;
            end
        end
    endtask

    // let all outstanding responses come back
    task automatic drain_responses();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == TIMEOUT_CYCLES) begin
                $display("timeout while waiting for lsu_valid_o");
                abort_run();
            end
            @(posedge clk_i);
            clear_strobes();
            @(negedge clk_i);
            collect_response();
            waited++;
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin : stimulus_proc
        int                   fd;
        int                   n;
        string                line;
        string                rest;
        byte                  op;
        logic [63:0]          fld [7];
        mmu_pkg::tlb_update_t upd;
        lookup_exp_t          e;
        rst_ni       = 1'b0;
        flush_i      = 1'b0;
        tlb_update_i = '0;
        lsu_req_i    = 1'b0;
        xlate_req_i  = '0;
        en_trans_i   = 1'b0;
        priv_lvl_i   = mmu_pkg::PRIV_LVL_M;
        sum_i        = 1'b0;
        asid_i       = '0;
        n_rsp        = 0;
        fd = $fopen("tb/mmu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tb/mmu_stimulus.txt");
            abort_run();
        end
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;
        while ($fgets(line, fd) != 0) begin
            op   = line.getc(0);
            rest = line.substr(1, line.len() - 1);
            // config and tlb changes wait for an idle pipeline
            if (op == "U" || op == "F" || op == "C") begin
                drain_responses();
            end
            if (op == "U" || op == "F" || op == "C" || op == "L") begin
                @(posedge clk_i);
                clear_strobes();
            end
            case (op)
                "U": begin
                    n = $sscanf(rest, "%h %h %h %h %h %h",
                                fld[0], fld[1], fld[2], fld[3], fld[4], fld[5]);
                    if (n != 6) begin
                        $display("malformed update line: %s", line);
                        abort_run();
                    end
                    upd.valid = 1'b1;
                    upd.vpn   = fld[0][`MMU_VPNW-1:0];
                    upd.asid  = fld[1][`MMU_ASIDW-1:0];
                    // ppn followed by the flags d a g u x w r v
                    upd.pte   = {fld[2][`MMU_PPNW-1:0], fld[3][7:0]};
                    upd.is_2m = fld[4][0];
                    upd.is_1g = fld[5][0];
                    tlb_update_i <= upd;
                end
                "F": flush_i <= 1'b1;
                "C": begin
                    n = $sscanf(rest, "%h %h %h %h", fld[0], fld[1], fld[2], fld[3]);
                    if (n != 4) begin
                        $display("malformed config line: %s", line);
                        abort_run();
                    end
                    en_trans_i <= fld[0][0];
                    priv_lvl_i <= mmu_pkg::priv_lvl_t'(fld[1][1:0]);
                    sum_i      <= fld[2][0];
                    asid_i     <= fld[3][`MMU_ASIDW-1:0];
                end
                "L": begin
                    n = $sscanf(rest, "%h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                                fld[3], fld[4], fld[5], fld[6]);
                    if (n != 7) begin
                        $display("malformed lookup line: %s", line);
                        abort_run();
                    end
                    xlate_req_i <= {fld[0][`MMU_VLEN-1:0], fld[1][0]};
                    lsu_req_i   <= 1'b1;
                    // hit is combinational and sampled mid-cycle
                    @(negedge clk_i);
                    check_value("lsu_hit_o", lsu_hit_o, fld[2]);
                    // response of the previous lookup when there is one
                    collect_response();
                    e.vaddr    = fld[0][`MMU_VLEN-1:0];
                    e.paddr    = fld[3][`MMU_PLEN-1:0];
                    e.miss     = fld[4][0];
                    e.ex_valid = fld[5][0];
                    e.cause    = fld[6][3:0];
                    exp_q.push_back(e);
                end
                default: begin
                    // comment or blank line
                end
            endcase
        end
        $fclose(fd);
        drain_responses();
        if (n_rsp > 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("the stimulus file produced no lookup responses");
            abort_run();
        end
    end

endmodule

/* tb/mmu_stimulus.txt */
# U vpn asid ppn flags(d a g u x w r v) is_2m is_1g | F | C en_trans priv sum asid
# L vaddr is_store exp_hit exp_paddr exp_miss exp_ex_valid exp_cause (hex, paddr unused on miss)
C 0 1 0 05
L 0000123abc 0 1 00000000123abc 0 0 0
L 7fffffffff 1 1 00007fffffffff 0 0 0
U 0000123 05 00000abcde c7 0 0
U 0040400 05 0000055555 c7 1 0
U 00c0000 05 000007ffff e7 0 1
C 1 1 0 05
L 0000123abc 0 1 000000abcdeabc 0 0 0
L 00405ab321 0 1 000000555ab321 0 0 0
L 00d2345678 1 1 00000052345678 0 0 0
C 1 1 0 09
L 0000123abc 0 0 0 1 0 0
L 00d2345678 0 1 00000052345678 0 0 0
C 1 1 0 05
U 0000200 05 0000000777 d7 0 0
U 0000300 05 0000000888 c3 0 0
L 0000123abc 0 0 0 1 0 0
L 0000200010 0 1 00000000777010 0 1 d
L 0000300044 1 1 00000000888044 0 1 f
C 1 1 1 05
L 0000200010 1 1 00000000777010 0 0 0
C 1 0 0 05
L 00d2345678 0 1 00000052345678 0 1 d
U 0000400 05 0000000999 47 0 0
C 1 1 0 05
L 0000400008 1 1 00000000999008 0 1 f
F
L 00d2345678 0 0 0 1 0 0
L 0000200010 0 0 0 1 0 0
U 0000600 05 0000000aaa c7 0 0
U 0000700 05 0000000bbb c7 0 0
U 0000600 05 0000000ccc c7 0 0
L 0000600123 0 1 00000000aaa123 0 0 0
L 0000700456 0 1 00000000bbb456 0 0 0

/* filelist.f */
+incdir+verilog
verilog/mmu_pkg.sv
verilog/dtlb.sv
verilog/page_resolve.sv
verilog/xlate_ctrl.sv
verilog/mmu_top.sv
tb/mmu_sva.sv
tb/mmu_tb.sv

/* Makefile */
# verilator flow for the sv39 data-side mmu

VERILATOR ?= verilator
TOP       ?= mmu_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
